// ==== design/memBusPkg.sv ====
package memBusPkg;

    // byte address as seen by the memory controller.
    typedef logic [31:0] addrT;

    // one data word, little-endian byte lanes.
    typedef logic [31:0] dataT;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOpE;

    // access length, 1, 2 or 4 bytes.
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } memLenE;

    // request from the data cache to the controller.
    typedef struct packed {
        memOpE  op;
        memLenE len;
        addrT   addr;
        dataT   data;
    } memReqS;

endpackage

// ==== design/lsuPkg.sv ====
package lsuPkg;

    import memBusPkg::*;

    // tag of the issuing instruction, returned with load data.
    typedef logic [3:0] tagT;

    // request as it enters the load/store buffer.
    typedef struct packed {
        memOpE  op;
        memLenE len;
        addrT   addr;
        dataT   data;
        tagT    tag;
    } lsuReqS;

    // load result, zero-extended data plus tag.
    typedef struct packed {
        dataT data;
        tagT  tag;
    } lsuResS;

endpackage

// ==== design/loadStoreBuffer.sv ====
`timescale 1ns/10ps

module loadStoreBuffer import lsuPkg::*; #(
    parameter int BufDepth = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   reqEn,
    input  lsuReqS req,
    input  logic   busy,
    output logic   full,
    output logic   issueEn,
    output lsuReqS issueReq
);

    localparam int PtrW = $clog2(BufDepth);

    lsuReqS          entries [BufDepth];
    logic [PtrW-1:0] headPtr;
    logic [PtrW-1:0] tailPtr;
    logic [PtrW:0]   count;
    logic [PtrW:0]   countNext;
    logic            push;
    logic            pop;

    // a request held while full is simply not taken.
    assign push = reqEn && !full;

    // the head leaves only when the cache can take it.
    assign pop = !busy && (count != '0);

    always_comb begin
        countNext = count + {{PtrW{1'b0}}, push} - {{PtrW{1'b0}}, pop};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
            full    <= 1'b0;
            issueEn <= 1'b0;
        end else if (rdy) begin
            issueEn <= pop;
            if (push) begin
                entries[tailPtr] <= req;
                tailPtr          <= tailPtr + 1'b1;
            end
            if (pop) begin
                issueReq <= entries[headPtr];
                headPtr  <= headPtr + 1'b1;
            end
            count <= countNext;
            full  <= (countNext == (PtrW + 1)'(BufDepth));
        end
    end

    // a push into a full queue would overwrite the head.
    assert property (@(posedge clk) disable iff (rst)
        (rdy && count == (PtrW + 1)'(BufDepth)) |-> !push);

endmodule

// ==== design/dataCache.sv ====
`timescale 1ns/10ps

module dataCache import memBusPkg::*, lsuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   issueEn,
    input  lsuReqS issueReq,
    input  logic   mcDone,
    input  dataT   mcData,
    output logic   busy,
    output logic   mcEn,
    output memReqS mcReq,
    output logic   doneEn,
    output lsuResS res
);

    logic  occupied;
    tagT   savedTag;
    memOpE savedOp;

    // the issue cycle counts as busy so the buffer cannot issue twice.
    always_comb begin
        busy = rst || occupied || issueEn;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcEn     <= 1'b0;
            doneEn   <= 1'b0;
            occupied <= 1'b0;
            savedOp  <= opLoad;
        end else if (rdy) begin
            mcEn   <= issueEn;
            doneEn <= 1'b0;
            if (mcDone) begin
                occupied <= 1'b0;
                // stores complete silently.
                if (savedOp == opLoad) begin
                    doneEn <= 1'b1;
                    res    <= '{data: mcData, tag: savedTag};
                end
            end
            if (issueEn) begin
                mcReq    <= '{op: issueReq.op, len: issueReq.len,
                              addr: issueReq.addr, data: issueReq.data};
                savedTag <= issueReq.tag;
                savedOp  <= issueReq.op;
                occupied <= 1'b1;
            end
        end
    end

    // one access in flight, the buffer must respect busy.
    assert property (@(posedge clk) disable iff (rst) issueEn |-> !occupied);

    // the controller only answers an access we forwarded.
    assert property (@(posedge clk) disable iff (rst) mcDone |-> occupied);

endmodule

// ==== design/memController.sv ====
`timescale 1ns/10ps

module memController import memBusPkg::*; #(
    parameter int MemBytes = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   mcEn,
    input  memReqS mcReq,
    output logic   mcDone,
    output dataT   mcData
);

    localparam int AddrW = $clog2(MemBytes);

    typedef enum logic [1:0] {
        stIdle,
        stAccess,
        stDone
    } stateE;

    stateE            state;
    logic [7:0]       ram [MemBytes];
    logic [AddrW-1:0] baseAddr;
    logic [AddrW-1:0] byteAddr;
    logic [1:0]       byteCnt;
    logic [1:0]       lastByte;
    memOpE            curOp;
    dataT             storeData;

    initial begin
        for (int i = 0; i < MemBytes; i++) begin
            ram[i] = 8'h00;
        end
    end

    // addresses wrap inside the RAM.
    assign byteAddr = baseAddr + AddrW'(byteCnt);

    // done is held for the single cycle spent in stDone.
    assign mcDone = (state == stDone);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            byteCnt <= 2'd0;
        end else if (rdy) begin
            case (state)
                stIdle: begin
                    if (mcEn) begin
                        baseAddr  <= mcReq.addr[AddrW-1:0];
                        curOp     <= mcReq.op;
                        storeData <= mcReq.data;
                        byteCnt   <= 2'd0;
                        // zero the result so short loads come back zero-extended.
                        mcData    <= '0;
                        case (mcReq.len)
                            lenByte: lastByte <= 2'd0;
                            lenHalf: lastByte <= 2'd1;
                            default: lastByte <= 2'd3;
                        endcase
                        state <= stAccess;
                    end
                end
                stAccess: begin
                    if (curOp == opStore) begin
                        ram[byteAddr] <= storeData[byteCnt*8 +: 8];
                    end else begin
                        mcData[byteCnt*8 +: 8] <= ram[byteAddr];
                    end
                    if (byteCnt == lastByte) begin
                        state <= stDone;
                    end else begin
                        byteCnt <= byteCnt + 2'd1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // the cache waits for done before sending the next access.
    assert property (@(posedge clk) disable iff (rst) mcEn |-> state == stIdle);

endmodule

// ==== design/memSubsystem.sv ====
`timescale 1ns/10ps

module memSubsystem import memBusPkg::*, lsuPkg::*; #(
    parameter int BufDepth = 8,
    parameter int MemBytes = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   reqEn,
    input  lsuReqS req,
    output logic   full,
    output logic   doneEn,
    output lsuResS res
);

    logic   issueEn;
    lsuReqS issueReq;
    logic   busy;
    logic   mcEn;
    memReqS mcReq;
    logic   mcDone;
    dataT   mcData;

    loadStoreBuffer #(
        .BufDepth (BufDepth)
    ) buf_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .reqEn    (reqEn),
        .req      (req),
        .busy     (busy),
        .full     (full),
        .issueEn  (issueEn),
        .issueReq (issueReq)
    );

    dataCache cache_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .issueEn  (issueEn),
        .issueReq (issueReq),
        .mcDone   (mcDone),
        .mcData   (mcData),
        .busy     (busy),
        .mcEn     (mcEn),
        .mcReq    (mcReq),
        .doneEn   (doneEn),
        .res      (res)
    );

    memController #(
        .MemBytes (MemBytes)
    ) ctrl_i (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .mcEn   (mcEn),
        .mcReq  (mcReq),
        .mcDone (mcDone),
        .mcData (mcData)
    );

endmodule

// ==== bench/memChecker.sv ====
`timescale 1ns/10ps

module memChecker import memBusPkg::*, lsuPkg::*; #(
    parameter int MemBytes = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   reqEn,
    input  lsuReqS req,
    input  logic   full,
    input  logic   doneEn,
    input  lsuResS res,
    output int     errCount,
    output int     resultCount,
    output int     pendingCount
);

    logic [7:0] model [MemBytes];
    lsuResS     expQ [$];
    lsuResS     want;
    logic       afterReset;
    logic       lastRdy;
    logic       lastDone;
    logic       lastFull;

    // byte i of an access, wrapped inside the RAM.
    function automatic int byteAddr(addrT addr, int i);
        return int'((addr + addrT'(i)) % addrT'(MemBytes));
    endfunction

    function automatic int byteCount(memLenE len);
        return (len == lenByte) ? 1 : ((len == lenHalf) ? 2 : 4);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error: %s = %h, expected %h", name, got, expected);
            errCount++;
        end
    endtask

    initial begin
        for (int i = 0; i < MemBytes; i++) begin
            model[i] = 8'h00;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            errCount    = 0;
            resultCount = 0;
            expQ.delete();
            afterReset  = 1'b1;
        end else begin
            if (afterReset) begin
                checkValue("full", 32'(full), 32'h0);
                checkValue("doneEn", 32'(doneEn), 32'h0);
            end else if (!lastRdy) begin
                // nothing may move across an edge with rdy low.
                checkValue("doneEn", 32'(doneEn), 32'(lastDone));
                checkValue("full", 32'(full), 32'(lastFull));
            end
            afterReset = 1'b0;
            // a result is taken on the enabled edge that clears the pulse.
            if (doneEn && rdy) begin
                if (expQ.size() == 0) begin
                    $display("unexpected doneEn with no load outstanding, tag %h", res.tag);
                    errCount++;
                end else begin
                    want = expQ.pop_front();
                    resultCount++;
                    checkValue("res.data", res.data, want.data);
                    checkValue("res.tag", 32'(res.tag), 32'(want.tag));
                end
            end
            if (reqEn && rdy && !full) begin
                want.data = 32'h0;
                want.tag  = req.tag;
                for (int i = 0; i < byteCount(req.len); i++) begin
                    if (req.op == opStore) begin
                        model[byteAddr(req.addr, i)] = req.data[i*8 +: 8];
                    end else begin
                        want.data[i*8 +: 8] = model[byteAddr(req.addr, i)];
                    end
                end
                if (req.op == opLoad) begin
                    expQ.push_back(want);
                end
            end
        end
        pendingCount = expQ.size();
        lastRdy      = rdy;
        lastDone     = doneEn;
        lastFull     = full;
    end

endmodule

// ==== bench/memSubsystemTb.sv ====
`timescale 1ns/10ps

module memSubsystemTb import memBusPkg::*, lsuPkg::*; #(
    parameter int BufDepth = 8,
    parameter int MemBytes = 256
);

    localparam int WaitLimit = 1000;

    logic   clk;
    logic   rst;
    logic   rdy;
    logic   reqEn;
    lsuReqS req;
    logic   full;
    logic   doneEn;
    lsuResS res;
    int     errCount;
    int     resultCount;
    int     pendingCount;
    integer seed;
    int     rdyPct;
    int     loadsIssued;
    int     benchErrors;
    int     testCount;
    int     lastResults;
    int     lastErrors;
    logic   sawFull;
    logic   timedOut;

    memSubsystem #(.BufDepth(BufDepth), .MemBytes(MemBytes)) dut_i (.*);

    memChecker #(.MemBytes(MemBytes)) chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // once set, every later wait returns at once and the run closes.
    task automatic flagTimeout(input string why);
        $display("%s", why);
        timedOut = 1'b1;
    endtask

    // the request is held and re-presented until the DUT takes it.
    task automatic pushReq(input lsuReqS r);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && !timedOut) begin
            if (waited == WaitLimit) begin
                flagTimeout("timeout: a request was never accepted");
            end else begin
                rdy     = (randBelow(100) < rdyPct);
                reqEn   = 1'b1;
                req     = r;
                taken   = rdy && !full;
                sawFull = sawFull || full;
                @(negedge clk);
                waited++;
            end
        end
        reqEn = 1'b0;
        if (taken && r.op == opLoad) begin
            loadsIssued++;
        end
    endtask

    task automatic endTest(input string name);
        int waited;
        waited = 0;
        while (pendingCount != 0 && !timedOut) begin
            if (waited == WaitLimit) begin
                flagTimeout("timeout: loads still outstanding at the end of a test");
            end else begin
                rdy = (randBelow(100) < rdyPct);
                @(negedge clk);
                waited++;
            end
        end
        if (!timedOut) begin
            testCount++;
            $display("test %0d %s: %0d loads checked, %0d errors", testCount, name,
                     resultCount - lastResults, errCount + benchErrors - lastErrors);
            lastResults = resultCount;
            lastErrors  = errCount + benchErrors;
        end
    endtask

    task automatic runPhase(input string name, input int ops, input addrT base,
                            input int window, input int pct, input logic gaps,
                            input logic needFull);
        lsuReqS r;
        rdyPct  = pct;
        sawFull = 1'b0;
        for (int i = 0; i < ops && !timedOut; i++) begin
            r.op   = memOpE'(randBelow(2));
            r.len  = memLenE'(randBelow(3));
            r.addr = base + addrT'(randBelow(window));
            r.data = $random(seed);
            r.tag  = tagT'(randBelow(16));
            pushReq(r);
            if (gaps && randBelow(4) == 0) begin
                repeat (randBelow(4) + 1) begin
                    rdy = (randBelow(100) < rdyPct);
                    @(negedge clk);
                end
            end
        end
        if (needFull && !sawFull && !timedOut) begin
            $display("full never rose while the buffer was flooded");
            benchErrors++;
        end
        endTest(name);
    endtask

    initial begin
        addrT probe;
        seed        = 32'h8f25_df0a;
        rst         = 1'b1;
        rdy         = 1'b1;
        reqEn       = 1'b0;
        req         = '0;
        rdyPct      = 100;
        loadsIssued = 0;
        benchErrors = 0;
        testCount   = 0;
        lastResults = 0;
        lastErrors  = 0;
        sawFull     = 1'b0;
        timedOut    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 4; i++) begin
            probe = addrT'(randBelow(MemBytes));
            pushReq(lsuReqS'{opLoad, memLenE'(randBelow(3)), probe, 32'h0, tagT'(i)});
        end
        endTest("reset state");

        pushReq(lsuReqS'{opStore, lenWord, 32'h10, 32'h4433_2211, 4'h1});
        pushReq(lsuReqS'{opStore, lenByte, 32'h11, 32'h0000_00aa, 4'h2});
        pushReq(lsuReqS'{opStore, lenHalf, 32'h12, 32'h5566_ccbb, 4'h3});
        // these two run past the top of the RAM.
        pushReq(lsuReqS'{opStore, lenWord, addrT'(MemBytes - 2), 32'hdead_beef, 4'h4});
        pushReq(lsuReqS'{opStore, lenHalf, addrT'(MemBytes + 1), 32'h0000_7788, 4'h5});
        for (int a = 0; a < 8; a++) begin
            probe = (a < 4) ? addrT'(32'h10 + a) : addrT'(MemBytes - 6 + a);
            for (int l = 0; l < 3; l++) begin
                pushReq(lsuReqS'{opLoad, memLenE'(l), probe, 32'h0, tagT'(a * 3 + l)});
            end
        end
        endTest("length and byte order");

        runPhase("ordering and tags", 40, 32'h20, 32, 100, 1'b1, 1'b0);
        runPhase("back-pressure", 4 * BufDepth, 32'h30, 32, 100, 1'b0, 1'b1);
        runPhase("pause", 60, 32'h30, 32, 50, 1'b0, 1'b0);
        runPhase("random soak", 2000, 32'h40, 16, 75, 1'b1, 1'b0);

        if (!timedOut && resultCount != loadsIssued) begin
            $display("%0d results came back for %0d loads issued", resultCount, loadsIssued);
            benchErrors++;
        end
        $display("%0d tests, %0d loads issued, %0d results, %0d errors", testCount,
                 loadsIssued, resultCount, errCount + benchErrors);
        if (!timedOut && errCount + benchErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/memBusPkg.sv
design/lsuPkg.sv
design/loadStoreBuffer.sv
design/dataCache.sv
design/memController.sv
design/memSubsystem.sv
bench/memChecker.sv
bench/memSubsystemTb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module memSubsystemTb -f tb.f

sim:
	verilator --binary --timing --assert -j 0 --top-module memSubsystemTb -f tb.f
	@out=$$(./obj_dir/VmemSubsystemTb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
